// ==== source/rcfg_macros.svh ====
// Shared size constants for the reconfiguration path, included by packages and RTL that size buses
`ifndef RCFG_MACROS_SVH
`define RCFG_MACROS_SVH

// Width of the register address seen on the channel bus
`define RCFG_ADDR_WIDTH 8

// Width of the register data on both read and write paths
`define RCFG_DATA_WIDTH 32

// Number of registers in the channel bank
// Only the low address bits needed to pick one of them are decoded
`define RCFG_NUM_REGS 16

// Masters sharing the bus, the adaptation streamer and the user port
`define RCFG_NUM_MASTERS 2

// Entries in the fixed adaptation program
`define RCFG_PROG_LEN 4

`endif

// ==== source/rcfg_bus_pkg.sv ====
// Bus-side types for the channel register path, imported by every module that touches the bus
`include "rcfg_macros.svh"

package rcfg_bus_pkg;

  // One master's request toward the register bank
  // A master holds all fields stable until it sees waitrequest low
  typedef struct packed {
    logic                        read;
    logic                        write;
    logic [`RCFG_ADDR_WIDTH-1:0] address;
    logic [`RCFG_DATA_WIDTH-1:0] writedata;
  } avmm_req_t;

  // Response returned to one master
  // Readdata is only meaningful in the cycle where waitrequest is low
  typedef struct packed {
    logic                        waitrequest;
    logic [`RCFG_DATA_WIDTH-1:0] readdata;
  } avmm_rsp_t;

  // Positions of each master in the request and grant vectors
  // Bit 0 has the highest priority in the arbiter, so the streamer sits there
  typedef enum int unsigned {
    idx_adapt = 0,
    idx_user  = 1
  } master_idx_e;

endpackage

// ==== source/rcfg_stream_pkg.sv ====
// Adaptation program types and contents, used by the streamer and by the testbench for expected values
`include "rcfg_macros.svh"

package rcfg_stream_pkg;

  // One read-modify-write step of the adaptation program
  typedef struct packed {
    logic [`RCFG_ADDR_WIDTH-1:0] address;
    logic [`RCFG_DATA_WIDTH-1:0] mask;
    logic [`RCFG_DATA_WIDTH-1:0] value;
  } rcfg_op_t;

  // Fixed program touching registers 4 to 7
  // Each entry replaces only the masked field of its register
  localparam rcfg_op_t rcfg_program [`RCFG_PROG_LEN] = '{
    '{address: 8'h04, mask: 32'h0000_00ff, value: 32'h0000_005a},
    '{address: 8'h05, mask: 32'h0000_ff00, value: 32'h0000_3c00},
    '{address: 8'h06, mask: 32'hf000_000f, value: 32'ha000_0005},
    '{address: 8'h07, mask: 32'h00ff_ff00, value: 32'h0012_3400}
  };

  // New register value: old contents outside the mask, program value inside it
  function automatic logic [`RCFG_DATA_WIDTH-1:0] rcfg_merge(
    input logic [`RCFG_DATA_WIDTH-1:0] old_value,
    input rcfg_op_t                    op
  );
    return (old_value & ~op.mask) | (op.value & op.mask);
  endfunction

endpackage

// ==== source/rcfg_arbiter.sv ====
// Registered fixed-priority arbiter with grant hold, used by the master mux to pick the bus owner
`timescale 1ns/1ps

module rcfg_arbiter #(
  parameter int width = 2
) (
  input  logic             reconfig_clk,
  input  logic             reset,
  input  logic [width-1:0] req,
  output logic [width-1:0] grant
);

  // Lowest set request bit wins, bit 0 being the highest priority
  logic [width-1:0] pick;
  // Current owner is still requesting
  logic             hold;

  // Two's complement trick isolates the lowest set bit of the request vector
  assign pick = req & (~req + width'(1));
  assign hold = |(grant & req);

  // A held grant stays until its owner lets go
  // When the owner drops its request the grant returns to zero for one cycle
  // and only then goes to the next requester
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      grant <= '0;
    end else if (hold) begin
      grant <= grant;
    end else if (|grant) begin
      grant <= '0;
    end else begin
      grant <= pick;
    end
  end

  // Never more than one owner on the bus
  a_grant_onehot: assert property (
    @(posedge reconfig_clk) disable iff (reset)
    $onehot0(grant)
  );

  // Every grant bit was requested in the cycle before
  a_grant_had_req: assert property (
    @(posedge reconfig_clk) disable iff (reset)
    (grant & ~$past(req)) == '0
  );

endmodule

// ==== source/rcfg_master_mux.sv ====
// Grant-masked master mux with waitrequest split, placing the streamer and user port on one bus
`timescale 1ns/1ps
`include "rcfg_macros.svh"

module rcfg_master_mux import rcfg_bus_pkg::*; (
  input  logic      reconfig_clk,
  input  logic      reset,
  input  avmm_req_t user_req,
  input  avmm_req_t adapt_req,
  input  avmm_rsp_t bus_rsp,
  output avmm_rsp_t user_rsp,
  output avmm_rsp_t adapt_rsp,
  output avmm_req_t bus_req
);

  localparam int num_masters = `RCFG_NUM_MASTERS;

  // Requests gathered by grant position so the mux logic can loop over them
  avmm_req_t                master_req [num_masters];
  logic [num_masters-1:0]   master_active;
  logic [num_masters-1:0]   grant;
  logic [num_masters-1:0]   master_wait;

  assign master_req[idx_adapt] = adapt_req;
  assign master_req[idx_user]  = user_req;

  // A master asks for the bus whenever it drives a read or a write
  always_comb begin
    for (int i = 0; i < num_masters; i++) begin
      master_active[i] = master_req[i].read | master_req[i].write;
    end
  end

  rcfg_arbiter #(
    .width (num_masters)
  ) arb_i (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .req          (master_active),
    .grant        (grant)
  );

  // Each request is ANDed with its own grant bit and the results are ORed together
  // With a one-hot or zero grant this passes the owner through and idles the bus otherwise
  always_comb begin
    bus_req = '0;
    for (int i = 0; i < num_masters; i++) begin
      bus_req = avmm_req_t'(bus_req | ({$bits(avmm_req_t){grant[i]}} & master_req[i]));
    end
  end

  // A master without the grant always waits, the owner waits as long as the bank does
  assign master_wait = ~grant | {num_masters{bus_rsp.waitrequest}};

  // Readdata goes to both, only the owner sees it with waitrequest low
  assign adapt_rsp.waitrequest = master_wait[idx_adapt];
  assign adapt_rsp.readdata    = bus_rsp.readdata;
  assign user_rsp.waitrequest  = master_wait[idx_user];
  assign user_rsp.readdata     = bus_rsp.readdata;

  // The owner keeps its whole request unchanged until the bank completes it
  for (genvar i = 0; i < num_masters; i++) begin : g_hold_chk
    a_req_stable: assert property (
      @(posedge reconfig_clk) disable iff (reset)
      (grant[i] && master_active[i] && master_wait[i]) |=> $stable(master_req[i])
    );
  end

  // The bank never sees a read and a write together
  a_bus_rw_excl: assert property (
    @(posedge reconfig_clk) disable iff (reset)
    !(bus_req.read && bus_req.write)
  );

endmodule

// ==== source/rcfg_streamer.sv ====
// Adaptation streamer that plays the fixed program as read-modify-write accesses on its bus port
`timescale 1ns/1ps
`include "rcfg_macros.svh"

module rcfg_streamer import rcfg_bus_pkg::*, rcfg_stream_pkg::*; (
  input  logic      reconfig_clk,
  input  logic      reset,
  input  logic      start,
  input  avmm_rsp_t adapt_rsp,
  output avmm_req_t adapt_req,
  output logic      busy,
  output logic      done
);

  localparam int idx_w = (`RCFG_PROG_LEN > 1) ? $clog2(`RCFG_PROG_LEN) : 1;
  localparam logic [idx_w-1:0] last_idx = idx_w'(`RCFG_PROG_LEN - 1);

  // Read fetches the old value, write stores the merged one, finish pulses done
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_finish
  } state_e;

  state_e                      state;
  state_e                      state_next;
  logic [idx_w-1:0]            idx;
  // Old register contents captured when the read completes
  logic [`RCFG_DATA_WIDTH-1:0] rd_data;
  rcfg_op_t                    op;
  logic                        xfer_done;

  // Current program entry
  assign op = rcfg_program[idx];

  // The access in flight finishes in the cycle the bus stops waiting
  assign xfer_done = !adapt_rsp.waitrequest;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_next = st_read;
        end
      end
      st_read: begin
        if (xfer_done) begin
          state_next = st_write;
        end
      end
      st_write: begin
        if (xfer_done) begin
          state_next = (idx == last_idx) ? st_finish : st_read;
        end
      end
      // A start in the done cycle already counts as a new run
      st_finish: begin
        state_next = start ? st_read : st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      state <= st_idle;
      idx   <= '0;
    end else begin
      state <= state_next;
      // The index restarts with each new run and advances after each write
      if (state_next == st_read && (state == st_idle || state == st_finish)) begin
        idx <= '0;
      end else if (state == st_write && xfer_done && idx != last_idx) begin
        idx <= idx + idx_w'(1);
      end
    end
  end

  // Payload capture, only meaningful once the read has completed
  always_ff @(posedge reconfig_clk) begin
    if (state == st_read && xfer_done) begin
      rd_data <= adapt_rsp.readdata;
    end
  end

  // Request fields come straight from state so they stay stable while waiting
  always_comb begin
    adapt_req.read      = (state == st_read);
    adapt_req.write     = (state == st_write);
    adapt_req.address   = op.address;
    adapt_req.writedata = rcfg_merge(rd_data, op);
  end

  assign busy = (state == st_read) || (state == st_write);
  assign done = (state == st_finish);

  // Done appears only right after the last entry's write is accepted
  a_done_after_last: assert property (
    @(posedge reconfig_clk) disable iff (reset)
    done |-> $past(state == st_write && idx == last_idx && xfer_done)
  );

endmodule

// ==== source/rcfg_csr_bank.sv ====
// Channel register bank slave with one wait state per access, sitting at the end of the shared bus
`timescale 1ns/1ps
`include "rcfg_macros.svh"

module rcfg_csr_bank import rcfg_bus_pkg::*; (
  input  logic      reconfig_clk,
  input  logic      reset,
  input  avmm_req_t bus_req,
  output avmm_rsp_t bus_rsp
);

  localparam int reg_w = $clog2(`RCFG_NUM_REGS);

  logic [`RCFG_DATA_WIDTH-1:0] regs [`RCFG_NUM_REGS];
  // Only the low address bits select a register so upper bits alias
  logic [reg_w-1:0]            reg_idx;
  logic                        access;
  // Set in the second cycle of an access, which is the completion cycle
  logic                        ack;

  assign reg_idx = bus_req.address[reg_w-1:0];
  assign access  = bus_req.read | bus_req.write;

  // The first cycle of every access waits and the second completes
  // Clearing ack after completion makes a back-to-back access wait again
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access & ~ack;
    end
  end

  assign bus_rsp.waitrequest = access & ~ack;

  // Writes land on the completion edge
  always_ff @(posedge reconfig_clk) begin
    if (reset) begin
      for (int i = 0; i < `RCFG_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (bus_req.write && ack) begin
      regs[reg_idx] <= bus_req.writedata;
    end
  end

  // Read data follows the address and is sampled by the master on completion
  assign bus_rsp.readdata = regs[reg_idx];

  // An access that was made to wait comes back unchanged in its completion cycle
  // The write and the read data of that cycle then belong to the waited access
  a_access_held: assert property (
    @(posedge reconfig_clk) disable iff (reset)
    bus_rsp.waitrequest |=> access && $stable(bus_req)
  );

endmodule

// ==== source/xcvr_rcfg_top.sv ====
// Top level of the channel reconfiguration path, exposing the user bus port and the adaptation controls
`timescale 1ns/1ps

module xcvr_rcfg_top import rcfg_bus_pkg::*; (
  input  logic      reconfig_clk,
  input  logic      reset,
  // Starts one pass of the adaptation program
  input  logic      start,
  // External user master port
  input  avmm_req_t user_req,
  output avmm_rsp_t user_rsp,
  // Adaptation status
  output logic      busy,
  output logic      done
);

  // Streamer side of the mux
  avmm_req_t adapt_req;
  avmm_rsp_t adapt_rsp;
  // Shared bus into the register bank
  avmm_req_t bus_req;
  avmm_rsp_t bus_rsp;

  rcfg_streamer streamer_i (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .start        (start),
    .adapt_rsp    (adapt_rsp),
    .adapt_req    (adapt_req),
    .busy         (busy),
    .done         (done)
  );

  // The mux owns the arbiter, so bus ownership is decided here
  rcfg_master_mux mux_i (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .user_req     (user_req),
    .adapt_req    (adapt_req),
    .bus_rsp      (bus_rsp),
    .user_rsp     (user_rsp),
    .adapt_rsp    (adapt_rsp),
    .bus_req      (bus_req)
  );

  rcfg_csr_bank bank_i (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .bus_req      (bus_req),
    .bus_rsp      (bus_rsp)
  );

endmodule

// ==== testbench/rcfg_tb.sv ====
// Self-checking testbench for the reconfiguration top level, applies a stimulus table in a loop
`timescale 1ns/1ps
`include "rcfg_macros.svh"

module rcfg_tb import rcfg_bus_pkg::*, rcfg_stream_pkg::*; ();

  // Cycles to keep watching after a run ends
  // This is long enough for a wrongly restarted program to pulse done again
  localparam int settle_cycles = `RCFG_PROG_LEN * 4 + 8;

  // Kinds of table steps
  typedef enum logic [1:0] {
    op_write,
    op_read,
    op_start,
    op_wait
  } tb_op_e;

  // One table step
  // Exp_data holds the read value, or the total done count for a wait step
  typedef struct packed {
    tb_op_e                      op;
    logic [`RCFG_ADDR_WIDTH-1:0] addr;
    logic [`RCFG_DATA_WIDTH-1:0] data;
    logic [`RCFG_DATA_WIDTH-1:0] exp_data;
  } tb_entry_t;

  logic      reconfig_clk;
  logic      reset;
  logic      start;
  avmm_req_t user_req;
  avmm_rsp_t user_rsp;
  logic      busy;
  logic      done;

  tb_entry_t                   stim_q [$];
  // Expected register contents while the table is being built
  logic [`RCFG_DATA_WIDTH-1:0] model [`RCFG_NUM_REGS];
  int                          runs_expected;
  int                          done_count;
  logic                        done_prev;
  int                          cycle_count;
  int                          cycle_limit;
  int                          check_count;
  int                          value_errors;
  int                          other_errors;

  xcvr_rcfg_top dut_i (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .start        (start),
    .user_req     (user_req),
    .user_rsp     (user_rsp),
    .busy         (busy),
    .done         (done)
  );

  always #2 reconfig_clk = ~reconfig_clk;

  // Ends a run that stops making progress
  always @(posedge reconfig_clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Done pulses are counted mid-cycle
  // Busy must already be low while done is high
  always @(negedge reconfig_clk) begin
    if (reset) begin
      done_prev <= 1'b0;
    end else begin
      if (done) begin
        done_count++;
        check_flag("busy", busy, 1'b0);
        if (done_prev) begin
          other_errors++;
          $display("Done stayed high for more than one cycle at %0t", $time);
        end
      end
      done_prev <= done;
    end
  end

  task automatic check_rsp(input string name, input avmm_rsp_t actual,
                           input avmm_rsp_t expected);
    check_count++;
    if (actual.readdata !== expected.readdata) begin
      value_errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected.readdata,
               actual.readdata);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      value_errors++;
      $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  // Masked bits come from value and the rest stay as they were
  function automatic logic [`RCFG_DATA_WIDTH-1:0] apply_mask(
    input logic [`RCFG_DATA_WIDTH-1:0] old_value,
    input logic [`RCFG_DATA_WIDTH-1:0] mask,
    input logic [`RCFG_DATA_WIDTH-1:0] value
  );
    logic [`RCFG_DATA_WIDTH-1:0] result;
    for (int b = 0; b < `RCFG_DATA_WIDTH; b++) begin
      result[b] = mask[b] ? value[b] : old_value[b];
    end
    return result;
  endfunction

  task automatic write_step(input int addr, input logic [`RCFG_DATA_WIDTH-1:0] data);
    stim_q.push_back('{op_write, `RCFG_ADDR_WIDTH'(addr), data, '0});
    model[addr] = data;
  endtask

  task automatic read_step(input int addr);
    stim_q.push_back('{op_read, `RCFG_ADDR_WIDTH'(addr), '0, model[addr]});
  endtask

  // A pulse that should be ignored leaves the model and the run count alone
  task automatic start_step(input bit begins_run);
    rcfg_op_t op;
    stim_q.push_back('{op_start, '0, '0, '0});
    if (begins_run) begin
      for (int i = 0; i < `RCFG_PROG_LEN; i++) begin
        op = rcfg_program[i];
        model[op.address] = apply_mask(model[op.address], op.mask, op.value);
      end
      runs_expected++;
    end
  endtask

  task automatic wait_step();
    stim_q.push_back('{op_wait, '0, '0, `RCFG_DATA_WIDTH'(runs_expected)});
  endtask

  task automatic build_stimulus();
    for (int i = 0; i < `RCFG_NUM_REGS; i++) begin
      model[i] = '0;
    end
    // Every register comes out of reset as zero
    for (int i = 0; i < `RCFG_NUM_REGS; i++) begin
      read_step(i);
    end
    // Plain user writes and read-back
    for (int i = 0; i < 4; i++) begin
      write_step(i, 32'h1234_5678 + i * 32'h0101_0101);
    end
    for (int i = 0; i < 4; i++) begin
      read_step(i);
    end
    // Preload the program targets, run the program once and check the merged values
    for (int i = 4; i < 8; i++) begin
      write_step(i, 32'h5aa5_c33c ^ (i * 32'h1111_1111));
    end
    start_step(1'b1);
    wait_step();
    for (int i = 4; i < 8; i++) begin
      read_step(i);
    end
    // Fresh preload followed by user writes issued while the streamer starts
    for (int i = 4; i < 8; i++) begin
      write_step(i, 32'hffff_0000 - i * 32'h0011_0011);
    end
    start_step(1'b1);
    for (int i = 8; i < 12; i++) begin
      write_step(i, 32'hbeef_0000 | i);
    end
    wait_step();
    for (int i = 4; i < 12; i++) begin
      read_step(i);
    end
    // Random user writes over the whole bank and then a full read-back
    for (int i = 0; i < 24; i++) begin
      write_step($urandom_range(`RCFG_NUM_REGS - 1, 0), $urandom);
    end
    for (int i = 0; i < `RCFG_NUM_REGS; i++) begin
      read_step(i);
    end
    // A second start while busy must not give a second run
    for (int i = 4; i < 8; i++) begin
      write_step(i, 32'h0f0f_f0f0 + i);
    end
    start_step(1'b1);
    start_step(1'b0);
    wait_step();
    for (int i = 4; i < 8; i++) begin
      read_step(i);
    end
  endtask

  // One user access, entered and left at a falling edge
  // The response is taken in the completion cycle
  task automatic user_access(input logic is_write, input logic [`RCFG_ADDR_WIDTH-1:0] addr,
                             input logic [`RCFG_DATA_WIDTH-1:0] data, output avmm_rsp_t rsp);
    user_req.read      = ~is_write;
    user_req.write     = is_write;
    user_req.address   = addr;
    user_req.writedata = data;
    @(negedge reconfig_clk);
    while (user_rsp.waitrequest) begin
      @(negedge reconfig_clk);
    end
    rsp = user_rsp;
    // Hold the request through the completion edge
    @(negedge reconfig_clk);
    user_req = '0;
  endtask

  task automatic run_entry(input tb_entry_t e);
    avmm_rsp_t rsp;
    avmm_rsp_t exp_rsp;
    case (e.op)
      op_write: begin
        user_access(1'b1, e.addr, e.data, rsp);
      end
      op_read: begin
        user_access(1'b0, e.addr, '0, rsp);
        exp_rsp.waitrequest = 1'b0;
        exp_rsp.readdata    = e.exp_data;
        check_rsp($sformatf("user_rsp.readdata[reg %0d]", e.addr), rsp, exp_rsp);
      end
      op_start: begin
        start = 1'b1;
        @(negedge reconfig_clk);
        start = 1'b0;
        // The edge that takes a pulse from idle raises busy
        // A pulse that comes while busy finds it already high
        check_flag("busy", busy, 1'b1);
      end
      default: begin
        // Done may already have pulsed while earlier user accesses were stalled
        while (done_count < int'(e.exp_data)) begin
          @(posedge reconfig_clk);
        end
        repeat (settle_cycles) @(negedge reconfig_clk);
        @(posedge reconfig_clk);
        if (done_count != int'(e.exp_data)) begin
          other_errors++;
          $display("Done pulsed %0d times in total where %0d runs were started",
                   done_count, e.exp_data);
        end
        @(negedge reconfig_clk);
        check_flag("busy", busy, 1'b0);
      end
    endcase
  endtask

  initial begin
    reconfig_clk  = 1'b0;
    reset         = 1'b1;
    start         = 1'b0;
    user_req      = '0;
    runs_expected = 0;
    done_count    = 0;
    done_prev     = 1'b0;
    cycle_count   = 0;
    check_count   = 0;
    value_errors  = 0;
    other_errors  = 0;
    void'($urandom(32'hf6f7f7fd));
    build_stimulus();
    cycle_limit = stim_q.size() * 20 + `RCFG_PROG_LEN * 40 + 200;

    repeat (3) @(posedge reconfig_clk);
    @(negedge reconfig_clk);
    reset = 1'b0;

    // Idle state straight after reset
    // Nobody holds the bus yet
    @(negedge reconfig_clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("user_rsp.waitrequest", user_rsp.waitrequest, 1'b1);

    foreach (stim_q[i]) begin
      run_entry(stim_q[i]);
    end

    $display("Checks: %0d, value errors: %0d, other errors: %0d", check_count,
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== xcvr_rcfg.f ====
+incdir+source
source/rcfg_bus_pkg.sv
source/rcfg_stream_pkg.sv
source/rcfg_arbiter.sv
source/rcfg_master_mux.sv
source/rcfg_streamer.sv
source/rcfg_csr_bank.sv
source/xcvr_rcfg_top.sv
testbench/rcfg_tb.sv

// ==== Bender.yml ====
package:
  name: xcvr_rcfg

sources:
  - include_dirs:
      - source
    files:
      - source/rcfg_bus_pkg.sv
      - source/rcfg_stream_pkg.sv
      - source/rcfg_arbiter.sv
      - source/rcfg_master_mux.sv
      - source/rcfg_streamer.sv
      - source/rcfg_csr_bank.sv
      - source/xcvr_rcfg_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/rcfg_tb.sv
